// ==== bht.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module bht (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic [`XLEN-1:0]        pc_i,
    resolve_if.bht_mp               resolve_i,
    output frontend_pkg::bht_pred_t pred_o
);
    localparam int IDX_W = $clog2(`BHT_ENTRIES);

    logic [1:0]              cnt_q [`BHT_ENTRIES];
    logic [`BHT_ENTRIES-1:0] valid_q;
    logic [IDX_W-1:0]        rd_idx;
    logic [IDX_W-1:0]        wr_idx;
    logic                    update;

    // word index, bits [1:0] are always zero
    assign rd_idx = pc_i[IDX_W+1:2];
    assign wr_idx = resolve_i.pc[IDX_W+1:2];
    // only conditional branches train the table
    assign update = resolve_i.valid & resolve_i.is_branch;

    // msb of the counter gives the direction
    assign pred_o.valid = valid_q[rd_idx];
    assign pred_o.taken = cnt_q[rd_idx][1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (update) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update) begin
            if (!valid_q[wr_idx]) begin
                // first sighting starts weakly taken or weakly not taken
                cnt_q[wr_idx] <= resolve_i.taken ? 2'b10 : 2'b01;
            end else if (resolve_i.taken && cnt_q[wr_idx] != 2'b11) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'd1;
            end else if (!resolve_i.taken && cnt_q[wr_idx] != 2'b00) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'd1;
            end
        end
    end

endmodule

// ==== branch_predict.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module branch_predict (
    input  logic                    rsp_valid_i,
    input  logic [`XLEN-1:0]        rsp_pc_i,
    input  riscv_pkg::instr_t       rsp_instr_i,
    input  frontend_pkg::bht_pred_t bht_pred_i,
    output logic                    bp_valid_o,
    output logic [`XLEN-1:0]        predict_addr_o,
    output frontend_pkg::cf_e       cf_o
);
    import riscv_pkg::*;
    import frontend_pkg::*;

    btype_t           b_instr;
    jtype_t           j_instr;
    logic             is_branch;
    logic             is_jal;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] j_imm;
    logic             taken;

    // ----------------------------------------
    // instruction scan
    // ----------------------------------------
    assign b_instr = btype_t'(rsp_instr_i);
    assign j_instr = jtype_t'(rsp_instr_i);

    assign is_branch = (b_instr.opcode == OP_BRANCH);
    // jalr has no known target here and is left to execute
    assign is_jal = (j_instr.opcode == OP_JAL);

    // sign extended b immediate
    assign b_imm = {{(`XLEN-12){b_instr.imm12}}, b_instr.imm11,
                    b_instr.imm10_5, b_instr.imm4_1, 1'b0};
    // sign extended j immediate
    assign j_imm = {{(`XLEN-20){j_instr.imm20}}, j_instr.imm19_12,
                    j_instr.imm11, j_instr.imm10_1, 1'b0};

    // ----------------------------------------
    // direction
    // ----------------------------------------
    always_comb begin
        taken = 1'b0;
        cf_o  = CF_NONE;
        if (is_jal) begin
            taken = 1'b1;
            cf_o  = CF_JUMP;
        end else if (is_branch) begin
            if (bht_pred_i.valid) begin
                taken = bht_pred_i.taken;
            end else begin
                // static rule, backward taken
                taken = b_imm[`XLEN-1];
            end
            if (taken) cf_o = CF_BRANCH;
        end
    end

    assign bp_valid_o = rsp_valid_i & taken;

    // next pc of this word in either direction
    assign predict_addr_o = rsp_pc_i + (taken ? (is_jal ? j_imm : b_imm) : `XLEN'd4);

endmodule

// ==== fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic [`XLEN-1:0]     boot_addr_i,
    // exception return and trap entry
    input  logic                 eret_i,
    input  logic [`XLEN-1:0]     epc_i,
    input  logic                 ex_valid_i,
    input  logic [`XLEN-1:0]     trap_vector_i,
    // commit flush and debug entry
    input  logic                 set_pc_commit_i,
    input  logic [`XLEN-1:0]     pc_commit_i,
    input  logic                 set_debug_pc_i,
    resolve_if.pc_mp             resolve_i,
    // memory port
    output logic                 fetch_req_o,
    output logic [`XLEN-1:0]     fetch_addr_o,
    input  logic                 fetch_ready_i,
    input  logic                 fetch_valid_i,
    input  logic [`XLEN-1:0]     fetch_data_i,
    input  logic                 fetch_err_i,
    output logic                 fetch_kill_o,
    // queue and predictor feedback
    input  logic                 queue_ready_i,
    input  logic                 replay_i,
    input  logic [`XLEN-1:0]     replay_addr_i,
    input  logic                 bp_valid_i,
    input  logic [`XLEN-1:0]     predict_addr_i,
    // registered response for the scan stage
    output logic                 rsp_valid_o,
    output logic [`XLEN-1:0]     rsp_pc_o,
    output riscv_pkg::instr_t    rsp_instr_o,
    output frontend_pkg::fe_ex_e rsp_ex_o
);
    import frontend_pkg::*;

    logic [`XLEN-1:0] npc_d;
    logic [`XLEN-1:0] npc_q;
    // set through reset and the first cycle after it
    logic             npc_rst_load_q;
    // request was accepted while the path changed
    logic             stale_q;
    logic [`XLEN-1:0] req_addr_q;
    logic             mispredict;
    logic             kill_req;
    logic             if_ready;
    logic             rsp_take;

    // ----------------------------------------
    // request and kill
    // ----------------------------------------
    assign mispredict = resolve_i.valid & resolve_i.mispredict;

    // path change drops the response in flight and the request made now
    assign kill_req = mispredict | flush_i | replay_i;
    // a taken prediction only drops the response in flight
    assign fetch_kill_o = kill_req | bp_valid_i | stale_q;

    // no request while the queue could overflow
    assign fetch_req_o = ~npc_rst_load_q & queue_ready_i;
    // taken prediction is fetched in the same cycle
    assign fetch_addr_o = bp_valid_i ? predict_addr_i : npc_q;
    assign if_ready = fetch_req_o & fetch_ready_i;

    assign rsp_take = fetch_valid_i & ~fetch_kill_o;

    // ----------------------------------------
    // next pc, later lines win
    // ----------------------------------------
    always_comb begin : npc_select
        npc_d = npc_q;
        if (npc_rst_load_q) npc_d = boot_addr_i;
        if (bp_valid_i) npc_d = predict_addr_i;
        // sequential word step
        if (if_ready) npc_d = {fetch_addr_o[`XLEN-1:2], 2'b00} + `XLEN'd4;
        // refetch what the queue refused
        if (replay_i) npc_d = replay_addr_i;
        if (mispredict) npc_d = resolve_i.target;
        if (eret_i) npc_d = epc_i;
        if (ex_valid_i) npc_d = trap_vector_i;
        // restart after the committing instruction
        if (set_pc_commit_i) npc_d = pc_commit_i + `XLEN'd4;
        if (set_debug_pc_i) npc_d = `DEBUG_HALT_ADDR;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_rst_load_q <= 1'b1;
            npc_q          <= '0;
            stale_q        <= 1'b0;
            rsp_valid_o    <= 1'b0;
        end else begin
            npc_rst_load_q <= 1'b0;
            npc_q          <= npc_d;
            stale_q        <= if_ready & kill_req;
            rsp_valid_o    <= rsp_take;
        end
    end

    // ----------------------------------------
    // response register
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        // address of the accepted request, read back one cycle later
        if (if_ready) req_addr_q <= fetch_addr_o;
        if (rsp_take) begin
            rsp_pc_o    <= req_addr_q;
            // faulted data is zeroed so the scan finds no jump in it
            rsp_instr_o <= fetch_err_i ? '0 : fetch_data_i;
            rsp_ex_o    <= fetch_err_i ? FE_ACCESS_FAULT : FE_NONE;
        end
    end

endmodule

// ==== fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// address and data width
`define XLEN 32

// entries in the queue toward decode
`define QUEUE_DEPTH 4

// 2-bit counters in the branch history table
// indexed by pc bits above bit 1
`define BHT_ENTRIES 16

// fixed entry point of the debug halt routine
`define DEBUG_HALT_ADDR 32'h0000_0800

`endif

// ==== frontend.f ====
+incdir+.
riscv_pkg.sv
frontend_pkg.sv
resolve_if.sv
fetch_ctrl.sv
bht.sv
branch_predict.sv
instr_queue.sv
frontend.sv
tb_clock.sv
tb_frontend.sv

// ==== frontend.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module frontend (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic [`XLEN-1:0]     boot_addr_i,
    // resolved control flow from execute
    input  logic                 resolve_valid_i,
    input  logic [`XLEN-1:0]     resolve_pc_i,
    input  logic [`XLEN-1:0]     resolve_target_i,
    input  logic                 resolve_taken_i,
    input  logic                 resolve_mispredict_i,
    input  logic                 resolve_branch_i,
    // csr redirects
    input  logic                 eret_i,
    input  logic [`XLEN-1:0]     epc_i,
    input  logic                 ex_valid_i,
    input  logic [`XLEN-1:0]     trap_vector_i,
    input  logic                 set_pc_commit_i,
    input  logic [`XLEN-1:0]     pc_commit_i,
    input  logic                 set_debug_pc_i,
    // instruction memory
    output logic                 fetch_req_o,
    output logic [`XLEN-1:0]     fetch_addr_o,
    input  logic                 fetch_ready_i,
    input  logic                 fetch_valid_i,
    input  logic [`XLEN-1:0]     fetch_data_i,
    input  logic                 fetch_err_i,
    output logic                 fetch_kill_o,
    // toward decode
    output logic                 entry_valid_o,
    input  logic                 entry_ready_i,
    output logic [`XLEN-1:0]     entry_pc_o,
    output riscv_pkg::instr_t    entry_instr_o,
    output frontend_pkg::cf_e    entry_cf_o,
    output logic [`XLEN-1:0]     entry_target_o,
    output frontend_pkg::fe_ex_e entry_ex_o
);
    import riscv_pkg::*;
    import frontend_pkg::*;

    resolve_if resolve_bus ();

    logic             rsp_valid;
    logic [`XLEN-1:0] rsp_pc;
    instr_t           rsp_instr;
    fe_ex_e           rsp_ex;
    bht_pred_t        bht_pred;
    logic             bp_valid;
    logic [`XLEN-1:0] predict_addr;
    cf_e              cf;
    logic             queue_ready;
    logic             replay;
    logic [`XLEN-1:0] replay_addr;
    fetch_entry_t     push_entry;
    fetch_entry_t     queue_entry;

    // ----------------------------------------
    // resolve bus
    // ----------------------------------------
    assign resolve_bus.valid      = resolve_valid_i;
    assign resolve_bus.pc         = resolve_pc_i;
    assign resolve_bus.target     = resolve_target_i;
    assign resolve_bus.taken      = resolve_taken_i;
    assign resolve_bus.mispredict = resolve_mispredict_i;
    assign resolve_bus.is_branch  = resolve_branch_i;

    fetch_ctrl i_fetch_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .boot_addr_i     (boot_addr_i),
        .eret_i          (eret_i),
        .epc_i           (epc_i),
        .ex_valid_i      (ex_valid_i),
        .trap_vector_i   (trap_vector_i),
        .set_pc_commit_i (set_pc_commit_i),
        .pc_commit_i     (pc_commit_i),
        .set_debug_pc_i  (set_debug_pc_i),
        .resolve_i       (resolve_bus.pc_mp),
        .fetch_req_o     (fetch_req_o),
        .fetch_addr_o    (fetch_addr_o),
        .fetch_ready_i   (fetch_ready_i),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_data_i    (fetch_data_i),
        .fetch_err_i     (fetch_err_i),
        .fetch_kill_o    (fetch_kill_o),
        .queue_ready_i   (queue_ready),
        .replay_i        (replay),
        .replay_addr_i   (replay_addr),
        .bp_valid_i      (bp_valid),
        .predict_addr_i  (predict_addr),
        .rsp_valid_o     (rsp_valid),
        .rsp_pc_o        (rsp_pc),
        .rsp_instr_o     (rsp_instr),
        .rsp_ex_o        (rsp_ex)
    );

    // looked up with the registered pc during the scan cycle
    bht i_bht (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .pc_i      (rsp_pc),
        .resolve_i (resolve_bus.bht_mp),
        .pred_o    (bht_pred)
    );

    branch_predict i_branch_predict (
        .rsp_valid_i    (rsp_valid),
        .rsp_pc_i       (rsp_pc),
        .rsp_instr_i    (rsp_instr),
        .bht_pred_i     (bht_pred),
        .bp_valid_o     (bp_valid),
        .predict_addr_o (predict_addr),
        .cf_o           (cf)
    );

    // ----------------------------------------
    // queue entry
    // ----------------------------------------
    assign push_entry.pc     = rsp_pc;
    assign push_entry.instr  = rsp_instr;
    assign push_entry.cf     = cf;
    assign push_entry.target = predict_addr;
    assign push_entry.ex     = rsp_ex;

    instr_queue i_instr_queue (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .valid_i       (rsp_valid),
        .entry_i       (push_entry),
        .ready_o       (queue_ready),
        .replay_o      (replay),
        .replay_addr_o (replay_addr),
        .entry_o       (queue_entry),
        .entry_valid_o (entry_valid_o),
        .entry_ready_i (entry_ready_i)
    );

    assign entry_pc_o     = queue_entry.pc;
    assign entry_instr_o  = queue_entry.instr;
    assign entry_cf_o     = queue_entry.cf;
    assign entry_target_o = queue_entry.target;
    assign entry_ex_o     = queue_entry.ex;

endmodule

// ==== frontend_pkg.sv ====
`include "fetch_params.svh"

package frontend_pkg;

    // control flow that was predicted taken
    typedef enum logic [1:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP
    } cf_e;

    // exceptions raised while fetching
    typedef enum logic {
        FE_NONE,
        FE_ACCESS_FAULT
    } fe_ex_e;

    // one instruction handed to decode
    typedef struct packed {
        logic [`XLEN-1:0]  pc;
        riscv_pkg::instr_t instr;
        cf_e               cf;
        // predicted next pc
        logic [`XLEN-1:0]  target;
        fe_ex_e            ex;
    } fetch_entry_t;

    // history table lookup
    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

endpackage

// ==== instr_queue.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module instr_queue (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    // from the scan stage
    input  logic                       valid_i,
    input  frontend_pkg::fetch_entry_t entry_i,
    output logic                       ready_o,
    output logic                       replay_o,
    output logic [`XLEN-1:0]           replay_addr_o,
    // toward decode
    output frontend_pkg::fetch_entry_t entry_o,
    output logic                       entry_valid_o,
    input  logic                       entry_ready_i
);
    import frontend_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `QUEUE_DEPTH;

    fetch_entry_t     mem_q [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count_q == DEPTH);
    assign push = valid_i & ~full;
    assign pop  = entry_valid_o & entry_ready_i;

    // room for two more, one in the response register and one in flight
    assign ready_o = (count_q < DEPTH - 1'b1);

    // refused entry goes back to fetch
    assign replay_o      = valid_i & full;
    assign replay_addr_o = entry_i.pc;

    assign entry_o       = mem_q[rd_ptr_q];
    assign entry_valid_o = (count_q != '0);

    // ----------------------------------------
    // pointers
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap on the power of two depth
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) mem_q[wr_ptr_q] <= entry_i;
    end

endmodule

// ==== resolve_if.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

interface resolve_if;
    // report of one resolved control-flow instruction
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] target;
    logic             taken;
    logic             mispredict;
    logic             is_branch;

    // redirect of the next pc
    modport pc_mp (
        input valid,
        input mispredict,
        input target
    );

    // training of the history table
    modport bht_mp (
        input valid,
        input is_branch,
        input pc,
        input taken
    );
endinterface

// ==== riscv_pkg.sv ====
package riscv_pkg;

    // one fetched word, no compressed forms
    typedef logic [31:0] instr_t;

    // major opcodes in bits [6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } btype_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } jtype_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f frontend.f \
    --top-module tb_frontend -o sim_frontend

out="$(./obj_dir/sim_frontend 2>&1 || true)"
echo "$out"

if grep -qF 'All tests passed!' <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_no
);
    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset held low over the first ten rising edges
    initial begin
        rst_no = 1'b0;
        repeat (10) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

// ==== tb_frontend.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_frontend;
    import riscv_pkg::*;
    import frontend_pkg::*;

    // cycle budget of each test, the timeout is their sum
    localparam int RESET_CYCLES   = 12;
    localparam int SEQ_CYCLES     = 60;
    localparam int JAL_CYCLES     = 60;
    localparam int BRANCH_CYCLES  = 120;
    localparam int PRIO_CYCLES    = 200;
    localparam int BACKP_CYCLES   = 400;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + SEQ_CYCLES + JAL_CYCLES
                                    + BRANCH_CYCLES + PRIO_CYCLES + BACKP_CYCLES;

    // fixed redirect sources
    localparam logic [31:0] BOOT_ADDR = 32'h0000_0100;
    localparam logic [31:0] MISP_ADDR = 32'h0000_0400;
    localparam logic [31:0] EPC_ADDR  = 32'h0000_0440;
    localparam logic [31:0] TRAP_ADDR = 32'h0000_0480;
    localparam logic [31:0] COMMIT_PC = 32'h0000_04c0;

    logic        clk_i;
    logic        rst_ni;
    logic        flush_i;
    logic [31:0] boot_addr_i;
    logic        resolve_valid_i;
    logic [31:0] resolve_pc_i;
    logic [31:0] resolve_target_i;
    logic        resolve_taken_i;
    logic        resolve_mispredict_i;
    logic        resolve_branch_i;
    logic        eret_i;
    logic [31:0] epc_i;
    logic        ex_valid_i;
    logic [31:0] trap_vector_i;
    logic        set_pc_commit_i;
    logic [31:0] pc_commit_i;
    logic        set_debug_pc_i;
    logic        fetch_req_o;
    logic [31:0] fetch_addr_o;
    logic        fetch_ready_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_data_i;
    logic        fetch_err_i;
    logic        fetch_kill_o;
    logic        entry_valid_o;
    logic        entry_ready_i;
    logic [31:0] entry_pc_o;
    instr_t      entry_instr_o;
    cf_e         entry_cf_o;
    logic [31:0] entry_target_o;
    fe_ex_e      entry_ex_o;

    // 4 KB of instruction memory, word indexed
    logic [31:0]  mem [1024];
    logic [31:0]  fault_addr;
    logic         rand_en;
    integer       seed = 32'hec833639;
    fetch_entry_t obs_q [$];
    // addresses whose response the memory saw killed
    logic [31:0]  killed_q [$];
    int           err_count = 0;
    int           cycles = 0;

    tb_clock clock0 (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    frontend dut0 (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .flush_i              (flush_i),
        .boot_addr_i          (boot_addr_i),
        .resolve_valid_i      (resolve_valid_i),
        .resolve_pc_i         (resolve_pc_i),
        .resolve_target_i     (resolve_target_i),
        .resolve_taken_i      (resolve_taken_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .resolve_branch_i     (resolve_branch_i),
        .eret_i               (eret_i),
        .epc_i                (epc_i),
        .ex_valid_i           (ex_valid_i),
        .trap_vector_i        (trap_vector_i),
        .set_pc_commit_i      (set_pc_commit_i),
        .pc_commit_i          (pc_commit_i),
        .set_debug_pc_i       (set_debug_pc_i),
        .fetch_req_o          (fetch_req_o),
        .fetch_addr_o         (fetch_addr_o),
        .fetch_ready_i        (fetch_ready_i),
        .fetch_valid_i        (fetch_valid_i),
        .fetch_data_i         (fetch_data_i),
        .fetch_err_i          (fetch_err_i),
        .fetch_kill_o         (fetch_kill_o),
        .entry_valid_o        (entry_valid_o),
        .entry_ready_i        (entry_ready_i),
        .entry_pc_o           (entry_pc_o),
        .entry_instr_o        (entry_instr_o),
        .entry_cf_o           (entry_cf_o),
        .entry_target_o       (entry_target_o),
        .entry_ex_o           (entry_ex_o)
    );

    // ----------------------------------------
    // instruction encoding and memory
    // ----------------------------------------
    // addi x1, x0, word index
    function automatic logic [31:0] fill_word(input logic [9:0] idx);
        return {2'b00, idx, 5'd0, 3'b000, 5'd1, OP_IMM};
    endfunction

    // jal x0, imm
    function automatic logic [31:0] enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, OP_JAL};
    endfunction

    // beq x0, x0, imm
    function automatic logic [31:0] enc_beq(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    task automatic load_fill();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(10'(i));
        end
    endtask

    task automatic put_word(input logic [31:0] addr, input logic [31:0] word);
        mem[addr[11:2]] = word;
    endtask

    // expected entry for a pc, static rule only
    function automatic fetch_entry_t expect_entry(input logic [31:0] pc);
        fetch_entry_t e;
        logic [31:0]  w;
        logic [31:0]  imm;
        w        = mem[pc[11:2]];
        e.pc     = pc;
        e.instr  = w;
        e.cf     = CF_NONE;
        e.target = pc + 32'd4;
        e.ex     = FE_NONE;
        if (pc == fault_addr) begin
            e.ex = FE_ACCESS_FAULT;
        end else if (w[6:0] == OP_JAL) begin
            imm      = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            e.cf     = CF_JUMP;
            e.target = pc + imm;
        end else if (w[6:0] == OP_BRANCH) begin
            imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            // backward taken
            if (imm[31]) begin
                e.cf     = CF_BRANCH;
                e.target = pc + imm;
            end
        end
        return e;
    endfunction

    // ----------------------------------------
    // memory model and decode side
    // ----------------------------------------
    initial begin : mem_model
        logic        acc;
        logic [31:0] addr;
        integer      r;
        fetch_ready_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_data_i  = '0;
        fetch_err_i   = 1'b0;
        entry_ready_i = 1'b0;
        forever begin
            // request is settled well before the edge
            @(negedge clk_i);
            // addr still holds the address of the response shown now
            if (fetch_valid_i && fetch_kill_o) begin
                killed_q.push_back(addr);
            end
            acc  = fetch_req_o & fetch_ready_i;
            addr = fetch_addr_o;
            @(posedge clk_i);
            #1;
            // response one cycle after acceptance
            fetch_valid_i = acc;
            fetch_data_i  = mem[addr[11:2]];
            fetch_err_i   = acc & (addr == fault_addr);
            r             = $random(seed);
            fetch_ready_i = rand_en ? r[0] : 1'b1;
            r             = $random(seed);
            entry_ready_i = rand_en ? r[0] : 1'b1;
        end
    end

    // popped entries in order
    always @(negedge clk_i) begin : monitor
        fetch_entry_t e;
        if (rst_ni && entry_valid_o && entry_ready_i) begin
            e.pc     = entry_pc_o;
            e.instr  = entry_instr_o;
            e.cf     = entry_cf_o;
            e.target = entry_target_o;
            e.ex     = entry_ex_o;
            obs_q.push_back(e);
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_count++;
            stop_run();
        end
    endtask

    task automatic wait_entries(input int n);
        while (obs_q.size() < n) @(posedge clk_i);
    endtask

    // response for addr was dropped by a kill
    function automatic logic was_killed(input logic [31:0] addr);
        foreach (killed_q[i]) begin
            if (killed_q[i] == addr) return 1'b1;
        end
        return 1'b0;
    endfunction

    // follow the program from start and compare the first n entries
    task automatic compare_walk(input logic [31:0] start, input int n);
        fetch_entry_t exp;
        logic [31:0]  pc;
        pc = start;
        wait_entries(n);
        for (int i = 0; i < n; i++) begin
            exp = expect_entry(pc);
            check("entry_pc_o", obs_q[i].pc, exp.pc);
            // faulted words carry no usable data
            if (exp.ex == FE_NONE) check("entry_instr_o", obs_q[i].instr, exp.instr);
            check("entry_cf_o", 32'(obs_q[i].cf), 32'(exp.cf));
            check("entry_target_o", obs_q[i].target, exp.target);
            check("entry_ex_o", 32'(obs_q[i].ex), 32'(exp.ex));
            pc = exp.target;
        end
    endtask

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic redirect(input logic dbg, input logic commit, input logic trap,
                            input logic eret, input logic misp, input logic [31:0] target);
        @(posedge clk_i);
        #1;
        flush_i              = 1'b1;
        set_debug_pc_i       = dbg;
        set_pc_commit_i      = commit;
        ex_valid_i           = trap;
        eret_i               = eret;
        resolve_valid_i      = misp;
        resolve_mispredict_i = misp;
        resolve_target_i     = target;
        @(posedge clk_i);
        #1;
        flush_i              = 1'b0;
        set_debug_pc_i       = 1'b0;
        set_pc_commit_i      = 1'b0;
        ex_valid_i           = 1'b0;
        eret_i               = 1'b0;
        resolve_valid_i      = 1'b0;
        resolve_mispredict_i = 1'b0;
        // anything seen so far belongs to the old path
        obs_q.delete();
        killed_q.delete();
    endtask

    task automatic restart_at(input logic [31:0] addr);
        redirect(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, addr);
    endtask

    // resolved taken branch, no redirect
    task automatic report_taken(input logic [31:0] pc, input logic [31:0] target);
        @(posedge clk_i);
        #1;
        resolve_valid_i  = 1'b1;
        resolve_branch_i = 1'b1;
        resolve_taken_i  = 1'b1;
        resolve_pc_i     = pc;
        resolve_target_i = target;
        @(posedge clk_i);
        #1;
        resolve_valid_i  = 1'b0;
        resolve_branch_i = 1'b0;
        resolve_taken_i  = 1'b0;
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic sequential_fetch();
        // boot load straight out of reset
        compare_walk(BOOT_ADDR, 8);
    endtask

    task automatic jal_redirect();
        load_fill();
        put_word(32'h208, enc_jal(21'h40));
        restart_at(32'h200);
        compare_walk(32'h200, 6);
        // word behind the jal is in flight during the scan and gets killed
        check("fetch_kill_o", 32'(was_killed(32'h20c)), 32'd1);
    endtask

    task automatic branch_prediction();
        load_fill();
        // forward branch at 0x300, backward loop at 0x308
        put_word(32'h300, enc_beq(13'h010));
        put_word(32'h308, enc_beq(13'h1ff8));
        restart_at(32'h300);
        compare_walk(32'h300, 7);
        // train the forward branch toward taken
        report_taken(32'h300, 32'h310);
        report_taken(32'h300, 32'h310);
        restart_at(32'h300);
        wait_entries(2);
        check("entry_pc_o", obs_q[0].pc, 32'h300);
        check("entry_cf_o", 32'(obs_q[0].cf), 32'(CF_BRANCH));
        check("entry_target_o", obs_q[0].target, 32'h300 + 32'd16);
        check("entry_pc_o", obs_q[1].pc, 32'h300 + 32'd16);
    endtask

    task automatic redirect_priority();
        redirect(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, MISP_ADDR);
        compare_walk(`DEBUG_HALT_ADDR, 2);
        redirect(1'b0, 1'b1, 1'b1, 1'b1, 1'b1, MISP_ADDR);
        compare_walk(COMMIT_PC + 32'd4, 2);
        redirect(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, MISP_ADDR);
        compare_walk(TRAP_ADDR, 2);
        redirect(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, MISP_ADDR);
        compare_walk(EPC_ADDR, 2);
        redirect(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, MISP_ADDR);
        compare_walk(MISP_ADDR, 2);
    endtask

    task automatic backpressure_and_fault();
        load_fill();
        fault_addr = 32'h510;
        rand_en    = 1'b1;
        restart_at(32'h500);
        compare_walk(32'h500, 24);
        rand_en = 1'b0;
    endtask

    initial begin : main
        flush_i              = 1'b0;
        boot_addr_i          = BOOT_ADDR;
        resolve_valid_i      = 1'b0;
        resolve_pc_i         = '0;
        resolve_target_i     = '0;
        resolve_taken_i      = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_branch_i     = 1'b0;
        eret_i               = 1'b0;
        epc_i                = EPC_ADDR;
        ex_valid_i           = 1'b0;
        trap_vector_i        = TRAP_ADDR;
        set_pc_commit_i      = 1'b0;
        pc_commit_i          = COMMIT_PC;
        set_debug_pc_i       = 1'b0;
        // no fault until the last test
        fault_addr           = 32'hffff_fff0;
        rand_en              = 1'b0;
        load_fill();

        @(posedge rst_ni);
        sequential_fetch();
        jal_redirect();
        branch_prediction();
        redirect_priority();
        backpressure_and_fault();

        if (err_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "errors were counted");
        end
    end

endmodule
